// ==== common/aesRoundPkg.sv ====
// Round-key addition engine shared definitions
// Block and byte widths, fixed SRAM addresses and the stage FSM encodings
`default_nettype none

package aesRoundPkg;

	localparam int blockWidth = 128;
	localparam int byteWidth = 8;
	localparam int bytesPerBlock = 16;
	localparam int byteIdxWidth = $clog2(bytesPerBlock);
	localparam int addrWidth = 16;

	// Fixed word locations in the SRAM
	localparam logic [addrWidth-1:0] keyAddr = 16'd16;
	localparam logic [addrWidth-1:0] stateAddr = 16'd32;

	typedef enum logic [2:0]
	{
		fetchIdle,
		fetchKeyAddr,
		fetchKeyRead,
		fetchKeyCapture,
		fetchStateAddrSet,
		fetchStateRead,
		fetchStateCapture,
		fetchWaitDone
	} fetchState;

	typedef enum logic [1:0]
	{
		mixIdle,
		mixByteSelect,
		mixByteCommit
	} mixState;

	typedef enum logic [1:0]
	{
		writeIdle,
		writeAddrSetup,
		writeStrobe,
		writeFinish
	} writeState;

endpackage

`default_nettype wire

// ==== hdl/keyFetch.sv ====
// Fetch stage of the round-key engine
// Reads the round key and then the cipher state from SRAM and hands both
// to the byte mixer, then holds off new starts until the write stage is done
`timescale 1ns/1ps
`default_nettype none

module keyFetch
	import aesRoundPkg::*;
(
	input wire logic clk,
	input wire logic n_rst,
	input wire logic start,
	input wire logic done,
	input wire logic [blockWidth-1:0] sramReadData,
	output logic sramRead,
	output logic [addrWidth-1:0] fetchAddr,
	output logic blockValid,
	output logic [blockWidth-1:0] roundKey,
	output logic [blockWidth-1:0] cipherState
);

	fetchState state;
	fetchState nextState;
	logic [blockWidth-1:0] keyReg;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= fetchIdle;
		else
			state <= nextState;
	end

	// Key word is valid in the cycle after the read strobe
	always_ff @(posedge clk)
	begin
		if (state == fetchKeyCapture)
			keyReg <= sramReadData;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			fetchIdle:
				if (start)
					nextState = fetchKeyAddr;
			fetchKeyAddr:      nextState = fetchKeyRead;
			fetchKeyRead:      nextState = fetchKeyCapture;
			fetchKeyCapture:   nextState = fetchStateAddrSet;
			fetchStateAddrSet: nextState = fetchStateRead;
			fetchStateRead:    nextState = fetchStateCapture;
			fetchStateCapture: nextState = fetchWaitDone;
			fetchWaitDone:
				if (done)
					nextState = fetchIdle;
			default:           nextState = fetchIdle;
		endcase
	end

	always_comb
	begin
		sramRead = 1'b0;
		fetchAddr = '0;
		case (state)
			fetchKeyAddr:
				fetchAddr = keyAddr;
			fetchKeyRead:
			begin
				fetchAddr = keyAddr;
				sramRead = 1'b1;
			end
			fetchStateAddrSet:
				fetchAddr = stateAddr;
			fetchStateRead:
			begin
				fetchAddr = stateAddr;
				sramRead = 1'b1;
			end
			default:
				fetchAddr = '0;
		endcase
	end

	// State word goes to the mixer straight from the SRAM
	assign blockValid = (state == fetchStateCapture);
	assign roundKey = keyReg;
	assign cipherState = sramReadData;

endmodule

`default_nettype wire

// ==== hdl/byteMixer.sv ====
// Mixing stage of the round-key engine
// XORs key and state one byte lane at a time, low lane first,
// with a select cycle and a commit cycle per lane
`timescale 1ns/1ps
`default_nettype none

module byteMixer
	import aesRoundPkg::*;
(
	input wire logic clk,
	input wire logic n_rst,
	input wire logic blockValid,
	input wire logic [blockWidth-1:0] roundKey,
	input wire logic [blockWidth-1:0] cipherState,
	output logic mixValid,
	output logic [blockWidth-1:0] mixedBlock
);

	mixState state;
	mixState nextState;
	logic [byteIdxWidth-1:0] byteIdx;
	logic lastLane;
	logic [blockWidth-1:0] keyReg;
	logic [blockWidth-1:0] stateReg;
	logic [blockWidth-1:0] resultReg;
	logic [blockWidth-1:0] resultNext;
	logic [byteWidth-1:0] laneByte;

	assign lastLane = (byteIdx == byteIdxWidth'(bytesPerBlock - 1));

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= mixIdle;
			byteIdx <= '0;
		end
		else
		begin
			state <= nextState;
			if (state == mixIdle && blockValid)
				byteIdx <= '0;
			else if (state == mixByteCommit)
				byteIdx <= byteIdx + 1'b1;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			mixIdle:
				if (blockValid)
					nextState = mixByteSelect;
			mixByteSelect:
				nextState = mixByteCommit;
			mixByteCommit:
				nextState = lastLane ? mixIdle : mixByteSelect;
			default:
				nextState = mixIdle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (state == mixIdle && blockValid)
		begin
			keyReg <= roundKey;
			stateReg <= cipherState;
		end
		if (state == mixByteSelect)
			laneByte <= keyReg[byteIdx*byteWidth +: byteWidth] ^
				stateReg[byteIdx*byteWidth +: byteWidth];
		resultReg <= resultNext;
	end

	// Commit drops the lane byte into its slot
	always_comb
	begin
		resultNext = resultReg;
		if (state == mixByteCommit)
			resultNext[byteIdx*byteWidth +: byteWidth] = laneByte;
	end

	// Full result is visible during the last commit
	assign mixedBlock = resultNext;
	assign mixValid = (state == mixByteCommit) && lastLane;

endmodule

`default_nettype wire

// ==== hdl/resultWrite.sv ====
// Write stage of the round-key engine
// Stores the mixed block back at the state address and pulses done
`timescale 1ns/1ps
`default_nettype none

module resultWrite
	import aesRoundPkg::*;
(
	input wire logic clk,
	input wire logic n_rst,
	input wire logic mixValid,
	input wire logic [blockWidth-1:0] mixedBlock,
	output logic sramWrite,
	output logic [addrWidth-1:0] writeAddr,
	output logic [blockWidth-1:0] sramWriteData,
	output logic done
);

	writeState state;
	writeState nextState;
	logic [blockWidth-1:0] dataReg;
	logic busOwned;

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= writeIdle;
		else
			state <= nextState;
	end

	always_ff @(posedge clk)
	begin
		if (state == writeIdle && mixValid)
			dataReg <= mixedBlock;
	end

	always_comb
	begin
		case (state)
			writeIdle:      nextState = mixValid ? writeAddrSetup : writeIdle;
			writeAddrSetup: nextState = writeStrobe;
			writeStrobe:    nextState = writeFinish;
			default:        nextState = writeIdle;
		endcase
	end

	// Address and data held through setup and strobe
	assign busOwned = (state == writeAddrSetup) || (state == writeStrobe);
	assign writeAddr = busOwned ? stateAddr : '0;
	assign sramWriteData = busOwned ? dataReg : '0;
	assign sramWrite = (state == writeStrobe);
	assign done = (state == writeFinish);

endmodule

`default_nettype wire

// ==== hdl/roundKeyAdd.sv ====
// Round-key addition engine top level
// Fetch, mix and write stages sharing one SRAM port, one block in flight
`timescale 1ns/1ps
`default_nettype none

module roundKeyAdd
	import aesRoundPkg::*;
(
	input wire logic clk,
	input wire logic n_rst,
	input wire logic start,
	output logic done,
	output logic sramRead,
	output logic sramWrite,
	output logic [addrWidth-1:0] sramAddr,
	output logic [blockWidth-1:0] sramWriteData,
	input wire logic [blockWidth-1:0] sramReadData
);

	logic [addrWidth-1:0] fetchAddr;
	logic [addrWidth-1:0] writeAddr;
	logic blockValid;
	logic [blockWidth-1:0] roundKey;
	logic [blockWidth-1:0] cipherState;
	logic mixValid;
	logic [blockWidth-1:0] mixedBlock;

	keyFetch u_fetch
	(
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.done(done),
		.sramReadData(sramReadData),
		.sramRead(sramRead),
		.fetchAddr(fetchAddr),
		.blockValid(blockValid),
		.roundKey(roundKey),
		.cipherState(cipherState)
	);

	byteMixer u_mixer
	(
		.clk(clk),
		.n_rst(n_rst),
		.blockValid(blockValid),
		.roundKey(roundKey),
		.cipherState(cipherState),
		.mixValid(mixValid),
		.mixedBlock(mixedBlock)
	);

	resultWrite u_write
	(
		.clk(clk),
		.n_rst(n_rst),
		.mixValid(mixValid),
		.mixedBlock(mixedBlock),
		.sramWrite(sramWrite),
		.writeAddr(writeAddr),
		.sramWriteData(sramWriteData),
		.done(done)
	);

	// Idle stage drives zero so the addresses merge
	assign sramAddr = fetchAddr | writeAddr;

endmodule

`default_nettype wire

// ==== test/roundKeyAdd_props.sv ====
// Bound checks for the round-key engine
// SRAM port exclusivity, write address and single-cycle done
`timescale 1ns/1ps
`default_nettype none

module roundKeyAddProps
	import aesRoundPkg::*;
(
	input wire logic clk,
	input wire logic n_rst,
	input wire logic done,
	input wire logic sramRead,
	input wire logic sramWrite,
	input wire logic [addrWidth-1:0] sramAddr
);

	// One shared port
	readWriteExclusive: assert property (@(posedge clk) disable iff (!n_rst)
		!(sramRead && sramWrite))
		else $error("SRAM read and write strobes high in the same cycle");

	donePulse: assert property (@(posedge clk) disable iff (!n_rst)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	// Results only ever go back to the state word
	writeToState: assert property (@(posedge clk) disable iff (!n_rst)
		sramWrite |-> (sramAddr == stateAddr))
		else $error("SRAM write to an address other than the state word");

endmodule

bind roundKeyAdd roundKeyAddProps u_props
(
	.clk(clk),
	.n_rst(n_rst),
	.done(done),
	.sramRead(sramRead),
	.sramWrite(sramWrite),
	.sramAddr(sramAddr)
);

`default_nettype wire

// ==== test/roundKeyAddTb.sv ====
// Testbench for the round-key addition engine
// SRAM model, random key jobs chained through the state word,
// and a reference XOR model checked against every write
`timescale 1ns/1ps
`default_nettype none

module roundKeyAddTb
	import aesRoundPkg::*;
();

	localparam int jobCount = 40;
	localparam int cycleLimit = jobCount * 45 + 200;
	localparam int doneCycle = 41;
	localparam int memDepth = 64;

	logic clk;
	logic n_rst;
	logic start;
	logic done;
	logic sramRead;
	logic sramWrite;
	logic [addrWidth-1:0] sramAddr;
	logic [blockWidth-1:0] sramWriteData;
	logic [blockWidth-1:0] sramReadData;

	logic [blockWidth-1:0] mem [0:memDepth-1];
	logic [blockWidth-1:0] modelState;
	logic [blockWidth-1:0] expectedBlock;
	logic busy;
	int edgeCount;
	int cycleCount;
	int startEdge;
	int readsSeen;
	int writesSeen;
	int donesSeen;
	int jobsDone;
	int errorCount;

	roundKeyAdd u_dut
	(
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.done(done),
		.sramRead(sramRead),
		.sramWrite(sramWrite),
		.sramAddr(sramAddr),
		.sramWriteData(sramWriteData),
		.sramReadData(sramReadData)
	);

	always #10 clk = ~clk;

	// Read data shows up 1 ns into the cycle after the strobe
	always @(posedge clk)
	begin
		logic readHit;
		logic [blockWidth-1:0] readWord;
		readHit = sramRead && (int'(sramAddr) < memDepth);
		readWord = readHit ? mem[int'(sramAddr)] : '0;
		if (sramWrite && int'(sramAddr) < memDepth)
			mem[int'(sramAddr)] = sramWriteData;
		#1;
		if (readHit)
			sramReadData = readWord;
	end

	always @(posedge clk)
	begin
		logic accept;
		logic expectDone;
		edgeCount = edgeCount + 1;
		accept = n_rst && !busy && start;
		expectDone = busy && (edgeCount == startEdge + doneCycle);
		if (!n_rst)
		begin
			if (done || sramRead || sramWrite || sramAddr !== '0)
			begin
				$display("SRAM port or done active during reset at cycle %0d", edgeCount);
				errorCount++;
			end
		end
		else
		begin
			if (done !== expectDone)
			begin
				$display("Fail done: got %h expected %h at cycle %0d",
					done, expectDone, edgeCount);
				errorCount++;
			end
			if (!busy && (sramRead || sramWrite || sramAddr !== '0))
			begin
				$display("SRAM access with no job in flight at cycle %0d", edgeCount);
				errorCount++;
			end
			if (busy && sramRead)
			begin
				if (readsSeen == 0 && sramAddr !== keyAddr)
				begin
					$display("Fail sramAddr: got %h expected %h", sramAddr, keyAddr);
					errorCount++;
				end
				if (readsSeen == 1 && sramAddr !== stateAddr)
				begin
					$display("Fail sramAddr: got %h expected %h", sramAddr, stateAddr);
					errorCount++;
				end
				if (readsSeen >= 2 || writesSeen != 0)
				begin
					$display("Unexpected extra SRAM read in job %0d", jobsDone);
					errorCount++;
				end
				readsSeen++;
			end
			if (busy && sramWrite)
			begin
				if (readsSeen < 2 || writesSeen != 0)
				begin
					$display("SRAM write out of order in job %0d", jobsDone);
					errorCount++;
				end
				if (sramAddr !== stateAddr)
				begin
					$display("Fail sramAddr: got %h expected %h", sramAddr, stateAddr);
					errorCount++;
				end
				if (sramWriteData !== expectedBlock)
				begin
					$display("Fail sramWriteData: got %h expected %h",
						sramWriteData, expectedBlock);
					errorCount++;
				end
				writesSeen++;
			end
			if (done)
				donesSeen++;
		end
		if (expectDone)
		begin
			if (readsSeen != 2 || writesSeen != 1 || donesSeen != 1)
			begin
				$display("Job %0d saw %0d reads, %0d writes and %0d done pulses",
					jobsDone, readsSeen, writesSeen, donesSeen);
				errorCount++;
			end
			modelState = expectedBlock;
			busy = 1'b0;
			jobsDone++;
		end
		if (accept)
		begin
			busy = 1'b1;
			startEdge = edgeCount;
			readsSeen = 0;
			writesSeen = 0;
			donesSeen = 0;
		end
	end

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Errors: %0d  Jobs completed: %0d", errorCount, jobsDone);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic logic [blockWidth-1:0] randomBlock();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// Background pattern built from the full word address
	task automatic fillMemory();
		for (int i = 0; i < memDepth; i++)
			mem[i] = {8{16'(i) ^ 16'ha5c3}};
	endtask

	task automatic loadJob(input int jobIdx);
		logic [blockWidth-1:0] keyWord;
		keyWord = randomBlock();
		if (jobIdx == 0)
		begin
			modelState = randomBlock();
			mem[int'(stateAddr)] = modelState;
		end
		else if (mem[int'(stateAddr)] !== modelState)
		begin
			$display("Fail state word: got %h expected %h",
				mem[int'(stateAddr)], modelState);
			errorCount++;
		end
		mem[int'(keyAddr)] = keyWord;
		expectedBlock = keyWord ^ modelState;
	endtask

	// Stray starts keep coming while the job is busy
	task automatic runJob(input int jobIdx, input bit backToBack);
		int gap;
		gap = backToBack ? 0 : 1 + ($urandom % 3);
		repeat (gap)
		begin
			@(posedge clk);
			#1;
		end
		loadJob(jobIdx);
		start = 1'b1;
		@(posedge clk);
		#1;
		while (busy)
		begin
			start = ($urandom % 6 == 0);
			@(posedge clk);
			#1;
		end
		start = 1'b0;
	endtask

	task automatic finishRun();
		if (jobsDone != jobCount)
		begin
			$display("Only %0d of %0d jobs completed", jobsDone, jobCount);
			errorCount++;
		end
		$display("Errors: %0d  Jobs completed: %0d", errorCount, jobsDone);
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	endtask

	initial
	begin
		bit backToBack;
		void'($urandom(32'hc681));
		clk = 1'b0;
		n_rst = 1'b0;
		start = 1'b0;
		sramReadData = '0;
		busy = 1'b0;
		modelState = '0;
		expectedBlock = '0;
		edgeCount = 0;
		cycleCount = 0;
		startEdge = 0;
		readsSeen = 0;
		writesSeen = 0;
		donesSeen = 0;
		jobsDone = 0;
		errorCount = 0;
		fillMemory();
		repeat (8) @(posedge clk);
		#1 n_rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		for (int job = 0; job < jobCount; job++)
		begin
			backToBack = (job > 0) && ($urandom % 3 == 0);
			runJob(job, backToBack);
		end
		repeat (3) @(posedge clk);
		#1;
		finishRun();
	end

endmodule

`default_nettype wire

// ==== files.f ====
common/aesRoundPkg.sv
hdl/keyFetch.sv
hdl/byteMixer.sv
hdl/resultWrite.sv
hdl/roundKeyAdd.sv
test/roundKeyAdd_props.sv
test/roundKeyAddTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the round-key engine testbench with Verilator and runs it
# The run fails when the log holds the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f files.f \
	--top-module roundKeyAddTb -o roundKeyAddSim > sim.log 2>&1 \
	&& { ./obj_dir/roundKeyAddSim >> sim.log 2>&1 || echo "Simulation FAILED" >> sim.log; } \
	|| echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
